// File: design/io_pkg.sv
`default_nettype none

package io_pkg;

    localparam int N_DEV_DEF  = 9;          // device slots on the bus
    localparam int CODE_W_DEF = 6;          // device code width
    localparam int DATA_W_DEF = 16;         // bus word width
    localparam int MASK_BASE  = 7;          // mask bit of slot 0

    localparam int KZ_W    = 9;             // control pulses per device
    localparam int KZ_DOA  = 0;             // load A
    localparam int KZ_DOB  = 1;             // load B
    localparam int KZ_DOC  = 2;             // load C
    localparam int KZ_DIA  = 3;             // read A
    localparam int KZ_DIB  = 4;             // read B
    localparam int KZ_DIC  = 5;             // read C
    localparam int KZ_STRT = 6;             // start
    localparam int KZ_CLR  = 7;             // clear
    localparam int KZ_PLS  = 8;             // pulse

    localparam int STAT_W = 2;              // busy/done status

    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,
        OP_DOA    = 4'd1,
        OP_DOB    = 4'd2,
        OP_DOC    = 4'd3,
        OP_DIA    = 4'd4,
        OP_DIB    = 4'd5,
        OP_DIC    = 4'd6,
        OP_STRT   = 4'd7,
        OP_CLR    = 4'd8,
        OP_PLS    = 4'd9,
        OP_MSKO   = 4'd10,                  // load mask from output bus
        OP_INTEN  = 4'd11,
        OP_INTDS  = 4'd12,
        OP_SAMPLE = 4'd13,                  // sample masked requests
        OP_INTA   = 4'd14                   // interrupt acknowledge
    } io_op_e;

    typedef enum logic [1:0] {IRQ_OFF, IRQ_ARMED, IRQ_HELD} irq_state_e;

endpackage

`default_nettype wire

// File: design/io_cmd_ctrl.sv
`default_nettype none

module io_cmd_ctrl import io_pkg::*; (
    input  wire             i_DRPB,
    input  wire             rst_n,
    input  var  io_op_e     i_op,
    input  wire             i_any_req,      // some unmasked request present
    output logic [KZ_W-1:0] o_func,         // one-hot pulse select
    output logic            o_mask_ld,
    output logic            o_rd_data,
    output logic            o_rd_ack,
    output logic            o_snap_ld,
    output logic            o_snap_clr,
    output logic            o_irq,
    output logic            o_int_en
);

    irq_state_e state;
    irq_state_e state_nxt;

    // opcode decode, all outputs act on the coming edge
    always_comb begin
        o_func     = '0;
        o_mask_ld  = 1'b0;
        o_rd_data  = 1'b0;
        o_rd_ack   = 1'b0;
        o_snap_ld  = 1'b0;
        o_snap_clr = 1'b0;
        case (i_op)
            OP_DOA:    o_func[KZ_DOA] = 1'b1;
            OP_DOB:    o_func[KZ_DOB] = 1'b1;
            OP_DOC:    o_func[KZ_DOC] = 1'b1;
            OP_DIA: begin
                o_func[KZ_DIA] = 1'b1;
                o_rd_data      = 1'b1;
            end
            OP_DIB: begin
                o_func[KZ_DIB] = 1'b1;
                o_rd_data      = 1'b1;
            end
            OP_DIC: begin
                o_func[KZ_DIC] = 1'b1;
                o_rd_data      = 1'b1;
            end
            OP_STRT:   o_func[KZ_STRT] = 1'b1;
            OP_CLR:    o_func[KZ_CLR]  = 1'b1;
            OP_PLS:    o_func[KZ_PLS]  = 1'b1;
            OP_MSKO:   o_mask_ld  = 1'b1;
            OP_INTDS:  o_snap_clr = 1'b1;
            OP_SAMPLE: o_snap_ld  = (state != IRQ_OFF);   // ignored while disabled
            OP_INTA:   o_rd_ack   = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        state_nxt = state;
        if (i_op == OP_INTDS) begin
            state_nxt = IRQ_OFF;                           // from any state
        end else if (i_op == OP_INTEN && state == IRQ_OFF) begin
            state_nxt = IRQ_ARMED;
        end else if (i_op == OP_SAMPLE && state != IRQ_OFF) begin
            state_nxt = i_any_req ? IRQ_HELD : IRQ_ARMED;
        end
    end

    always_ff @(posedge i_DRPB or negedge rst_n) begin
        if (!rst_n) begin
            state <= IRQ_OFF;
        end else begin
            state <= state_nxt;
        end
    end

    assign o_irq    = (state == IRQ_HELD);
    assign o_int_en = (state != IRQ_OFF);

endmodule

`default_nettype wire

// File: design/dev_select.sv
`default_nettype none

module dev_select import io_pkg::*; #(
    parameter int N_DEV  = N_DEV_DEF,
    parameter int CODE_W = CODE_W_DEF
) (
    input  wire                          i_DRPB,
    input  wire                          rst_n,
    input  wire  [CODE_W-1:0]            i_addr,
    input  wire  [N_DEV-1:0][CODE_W-1:0] i_dev_code,
    input  wire  [KZ_W-1:0]              i_func,      // decoded pulse select
    output logic [N_DEV-1:0]             o_sel,
    output logic [N_DEV-1:0][KZ_W-1:0]   o_dev_kz
);

    // address compare, duplicate codes select both slots
    always_comb begin
        for (int k = 0; k < N_DEV; k++) begin
            o_sel[k] = (i_addr == i_dev_code[k]);
        end
    end

    // pulses last one cycle since i_func drops with the opcode
    always_ff @(posedge i_DRPB or negedge rst_n) begin
        if (!rst_n) begin
            o_dev_kz <= '0;
        end else begin
            for (int k = 0; k < N_DEV; k++) begin
                o_dev_kz[k] <= o_sel[k] ? i_func : '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/irq_mask_reg.sv
`default_nettype none

module irq_mask_reg import io_pkg::*; #(
    parameter int N_DEV  = N_DEV_DEF,
    parameter int DATA_W = DATA_W_DEF
) (
    input  wire               i_DRPB,
    input  wire               rst_n,
    input  wire               i_mask_ld,
    input  wire  [DATA_W-1:0] i_bus_wr,
    input  wire  [N_DEV-1:0]  i_dev_req,
    output logic [N_DEV-1:0]  o_req_m,
    output logic              o_any_req
);

    logic [DATA_W-1:0] mask_q;                  // set bit blocks the slot

    always_ff @(posedge i_DRPB or negedge rst_n) begin
        if (!rst_n) begin
            mask_q <= '0;
        end else if (i_mask_ld) begin
            mask_q <= i_bus_wr;
        end
    end

    always_comb begin
        for (int k = 0; k < N_DEV; k++) begin
            o_req_m[k] = i_dev_req[k] & ~mask_q[MASK_BASE + k];
        end
    end

    assign o_any_req = |o_req_m;

endmodule

`default_nettype wire

// File: design/irq_prio_enc.sv
`default_nettype none

module irq_prio_enc import io_pkg::*; #(
    parameter int N_DEV  = N_DEV_DEF,
    parameter int CODE_W = CODE_W_DEF
) (
    input  wire                          i_DRPB,
    input  wire                          rst_n,
    input  wire                          i_snap_ld,
    input  wire                          i_snap_clr,
    input  wire  [N_DEV-1:0]             i_req_m,     // masked requests
    input  wire  [N_DEV-1:0][CODE_W-1:0] i_dev_code,
    output logic [CODE_W-1:0]            o_ack_code
);

    logic [N_DEV-1:0] snap_q;

    // snapshot holds until the next sample or a disable
    always_ff @(posedge i_DRPB or negedge rst_n) begin
        if (!rst_n) begin
            snap_q <= '0;
        end else if (i_snap_clr) begin
            snap_q <= '0;
        end else if (i_snap_ld) begin
            snap_q <= i_req_m;
        end
    end

    // scan from the top so the lowest slot is written last and wins
    always_comb begin
        o_ack_code = '0;                        // empty snapshot reads zero
        for (int k = N_DEV - 1; k >= 0; k--) begin
            if (snap_q[k]) begin
                o_ack_code = i_dev_code[k];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/read_mux.sv
`default_nettype none

module read_mux import io_pkg::*; #(
    parameter int N_DEV  = N_DEV_DEF,
    parameter int CODE_W = CODE_W_DEF,
    parameter int DATA_W = DATA_W_DEF
) (
    input  wire                          i_DRPB,
    input  wire                          rst_n,
    input  wire                          i_rd_data,   // DIA/DIB/DIC
    input  wire                          i_rd_ack,    // INTA
    input  wire  [N_DEV-1:0]             i_sel,
    input  wire  [N_DEV-1:0][DATA_W-1:0] i_dev_data,
    input  wire  [N_DEV-1:0][STAT_W-1:0] i_dev_stat,
    input  wire  [CODE_W-1:0]            i_ack_code,
    output logic [DATA_W-1:0]            o_bus_rd,
    output logic [STAT_W-1:0]            o_dev_stat
);

    logic [DATA_W-1:0] data_or;
    logic [STAT_W-1:0] stat_or;

    // wired-or of all selected slots
    always_comb begin
        data_or = '0;
        stat_or = '0;
        for (int k = 0; k < N_DEV; k++) begin
            if (i_sel[k]) begin
                data_or = data_or | i_dev_data[k];
                stat_or = stat_or | i_dev_stat[k];
            end
        end
    end

    always_ff @(posedge i_DRPB or negedge rst_n) begin
        if (!rst_n) begin
            o_bus_rd   <= '0;
            o_dev_stat <= '0;
        end else begin
            if (i_rd_data) begin
                o_bus_rd <= data_or;
            end else if (i_rd_ack) begin
                o_bus_rd <= DATA_W'(i_ack_code);       // code in low bits
            end else begin
                o_bus_rd <= '0;
            end
            o_dev_stat <= stat_or;                  // follows i_addr every cycle
        end
    end

endmodule

`default_nettype wire

// File: design/io_ctrl_top.sv
`default_nettype none

module io_ctrl_top import io_pkg::*; #(
    parameter int N_DEV  = N_DEV_DEF,
    parameter int CODE_W = CODE_W_DEF,
    parameter int DATA_W = DATA_W_DEF
) (
    input  wire                               i_DRPB,
    input  wire                               rst_n,
    input  var  io_op_e                       i_op,         // one command per cycle
    input  wire [CODE_W-1:0]                  i_addr,       // bus device code
    input  wire [DATA_W-1:0]                  i_bus_wr,     // output bus word
    input  wire [N_DEV-1:0][CODE_W-1:0]       i_dev_code,
    input  wire [N_DEV-1:0][DATA_W-1:0]       i_dev_data,
    input  wire [N_DEV-1:0]                   i_dev_req,
    input  wire [N_DEV-1:0][STAT_W-1:0]       i_dev_stat,
    output wire [N_DEV-1:0][KZ_W-1:0]         o_dev_kz,
    output wire [DATA_W-1:0]                  o_bus_rd,     // read bus
    output wire [STAT_W-1:0]                  o_dev_stat,
    output wire                               o_irq,
    output wire                               o_int_en
);

    wire [KZ_W-1:0]   func;
    wire              mask_ld;
    wire              rd_data;
    wire              rd_ack;
    wire              snap_ld;
    wire              snap_clr;
    wire              any_req;
    wire [N_DEV-1:0]  sel;                                  // address match per slot
    wire [N_DEV-1:0]  req_m;                                // requests past the mask
    wire [CODE_W-1:0] ack_code;

    io_cmd_ctrl u_cmd_ctrl (
        .i_DRPB     (i_DRPB),
        .rst_n      (rst_n),
        .i_op       (i_op),
        .i_any_req  (any_req),
        .o_func     (func),
        .o_mask_ld  (mask_ld),
        .o_rd_data  (rd_data),
        .o_rd_ack   (rd_ack),
        .o_snap_ld  (snap_ld),
        .o_snap_clr (snap_clr),
        .o_irq      (o_irq),
        .o_int_en   (o_int_en)
    );

    dev_select #(.N_DEV(N_DEV), .CODE_W(CODE_W)) u_dev_select (
        .i_DRPB     (i_DRPB),
        .rst_n      (rst_n),
        .i_addr     (i_addr),
        .i_dev_code (i_dev_code),
        .i_func     (func),
        .o_sel      (sel),
        .o_dev_kz   (o_dev_kz)
    );

    irq_mask_reg #(.N_DEV(N_DEV), .DATA_W(DATA_W)) u_irq_mask_reg (
        .i_DRPB    (i_DRPB),
        .rst_n     (rst_n),
        .i_mask_ld (mask_ld),
        .i_bus_wr  (i_bus_wr),
        .i_dev_req (i_dev_req),
        .o_req_m   (req_m),
        .o_any_req (any_req)
    );

    irq_prio_enc #(.N_DEV(N_DEV), .CODE_W(CODE_W)) u_irq_prio_enc (
        .i_DRPB     (i_DRPB),
        .rst_n      (rst_n),
        .i_snap_ld  (snap_ld),
        .i_snap_clr (snap_clr),
        .i_req_m    (req_m),
        .i_dev_code (i_dev_code),
        .o_ack_code (ack_code)
    );

    read_mux #(.N_DEV(N_DEV), .CODE_W(CODE_W), .DATA_W(DATA_W)) u_read_mux (
        .i_DRPB     (i_DRPB),
        .rst_n      (rst_n),
        .i_rd_data  (rd_data),
        .i_rd_ack   (rd_ack),
        .i_sel      (sel),
        .i_dev_data (i_dev_data),
        .i_dev_stat (i_dev_stat),
        .i_ack_code (ack_code),
        .o_bus_rd   (o_bus_rd),
        .o_dev_stat (o_dev_stat)
    );

endmodule

`default_nettype wire

// File: verification/io_ctrl_tb.sv
`default_nettype none

module io_ctrl_tb import io_pkg::*; ();

    typedef struct packed {
        io_op_e                  op;
        logic [CODE_W_DEF-1:0]   addr;
        logic [DATA_W_DEF-1:0]   bus;
        logic [N_DEV_DEF-1:0]    req;
        logic [KZ_W-1:0]         kz;        // pulses expected at the addressed slot
        logic                    rd_dev;    // read bus carries the slot's data word
        logic [DATA_W_DEF-1:0]   rd;
        logic                    irq;
        logic                    en;
    } row_t;

    logic                                   clk;
    logic                                   rst_n;
    io_op_e                                 op;
    logic [CODE_W_DEF-1:0]                  addr;
    logic [DATA_W_DEF-1:0]                  bus_wr;
    logic [N_DEV_DEF-1:0][CODE_W_DEF-1:0]   dev_code;
    logic [N_DEV_DEF-1:0][DATA_W_DEF-1:0]   dev_data;
    logic [N_DEV_DEF-1:0]                   dev_req;
    logic [N_DEV_DEF-1:0][STAT_W-1:0]       dev_stat;
    wire  [N_DEV_DEF-1:0][KZ_W-1:0]         dev_kz;
    wire  [DATA_W_DEF-1:0]                  bus_rd;
    wire  [STAT_W-1:0]                      stat_rd;
    wire                                    irq;
    wire                                    int_en;

    row_t   rows [0:31];
    int     n_rows;
    int     row_idx;
    int     errors;
    int     n_checks;
    integer seed;

    io_ctrl_top dut (
        .i_DRPB     (clk),
        .rst_n      (rst_n),
        .i_op       (op),
        .i_addr     (addr),
        .i_bus_wr   (bus_wr),
        .i_dev_code (dev_code),
        .i_dev_data (dev_data),
        .i_dev_req  (dev_req),
        .i_dev_stat (dev_stat),
        .o_dev_kz   (dev_kz),
        .o_bus_rd   (bus_rd),
        .o_dev_stat (stat_rd),
        .o_irq      (irq),
        .o_int_en   (int_en)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s at step %0d: got %0h, expected %0h", name, row_idx, got, exp);
        end
    endtask

    task automatic add_row(input io_op_e r_op, input logic [CODE_W_DEF-1:0] r_addr,
                           input logic [DATA_W_DEF-1:0] r_bus, input logic [N_DEV_DEF-1:0] r_req,
                           input logic [KZ_W-1:0] r_kz, input logic r_rd_dev,
                           input logic [DATA_W_DEF-1:0] r_rd, input logic r_irq,
                           input logic r_en);
        rows[n_rows] = '{r_op, r_addr, r_bus, r_req, r_kz, r_rd_dev, r_rd, r_irq, r_en};
        n_rows++;
    endtask

    task automatic build_table();
        // control pulses, one slot at a time
        add_row(OP_NOP,    6'd7,  16'h0000, 9'h000, 9'h000, 1'b0, 16'h0000, 1'b0, 1'b0);
        add_row(OP_DOA,    6'd7,  16'h0000, 9'h000, 9'h001, 1'b0, 16'h0000, 1'b0, 1'b0);
        add_row(OP_DOB,    6'd9,  16'h0000, 9'h000, 9'h002, 1'b0, 16'h0000, 1'b0, 1'b0);
        add_row(OP_DOC,    6'd10, 16'h0000, 9'h000, 9'h004, 1'b0, 16'h0000, 1'b0, 1'b0);
        add_row(OP_DIA,    6'd8,  16'h0000, 9'h000, 9'h008, 1'b1, 16'h0000, 1'b0, 1'b0);
        add_row(OP_DIB,    6'd11, 16'h0000, 9'h000, 9'h010, 1'b1, 16'h0000, 1'b0, 1'b0);
        add_row(OP_DIC,    6'd15, 16'h0000, 9'h000, 9'h020, 1'b1, 16'h0000, 1'b0, 1'b0);
        add_row(OP_STRT,   6'd12, 16'h0000, 9'h000, 9'h040, 1'b0, 16'h0000, 1'b0, 1'b0);
        add_row(OP_CLR,    6'd13, 16'h0000, 9'h000, 9'h080, 1'b0, 16'h0000, 1'b0, 1'b0);
        add_row(OP_PLS,    6'd14, 16'h0000, 9'h000, 9'h100, 1'b0, 16'h0000, 1'b0, 1'b0);
        add_row(OP_DOA,    6'd3,  16'h0000, 9'h000, 9'h000, 1'b0, 16'h0000, 1'b0, 1'b0);
        add_row(OP_NOP,    6'd7,  16'h0000, 9'h000, 9'h000, 1'b0, 16'h0000, 1'b0, 1'b0);
        add_row(OP_DIA,    6'd40, 16'h0000, 9'h000, 9'h000, 1'b1, 16'h0000, 1'b0, 1'b0);
        // interrupt enable, sample and acknowledge
        add_row(OP_SAMPLE, 6'd7,  16'h0000, 9'h005, 9'h000, 1'b0, 16'h0000, 1'b0, 1'b0);
        add_row(OP_INTEN,  6'd8,  16'h0000, 9'h000, 9'h000, 1'b0, 16'h0000, 1'b0, 1'b1);
        add_row(OP_SAMPLE, 6'd9,  16'h0000, 9'h00c, 9'h000, 1'b0, 16'h0000, 1'b1, 1'b1);
        add_row(OP_INTA,   6'd10, 16'h0000, 9'h000, 9'h000, 1'b0, 16'h0009, 1'b1, 1'b1);
        add_row(OP_INTDS,  6'd11, 16'h0000, 9'h000, 9'h000, 1'b0, 16'h0000, 1'b0, 1'b0);
        add_row(OP_INTA,   6'd12, 16'h0000, 9'h000, 9'h000, 1'b0, 16'h0000, 1'b0, 1'b0);
        // mask slot 2, then all slots, then none
        add_row(OP_MSKO,   6'd13, 16'h0200, 9'h000, 9'h000, 1'b0, 16'h0000, 1'b0, 1'b0);
        add_row(OP_INTEN,  6'd14, 16'h0000, 9'h000, 9'h000, 1'b0, 16'h0000, 1'b0, 1'b1);
        add_row(OP_SAMPLE, 6'd15, 16'h0000, 9'h00c, 9'h000, 1'b0, 16'h0000, 1'b1, 1'b1);
        add_row(OP_INTA,   6'd7,  16'h0000, 9'h000, 9'h000, 1'b0, 16'h000a, 1'b1, 1'b1);
        add_row(OP_MSKO,   6'd8,  16'hff80, 9'h000, 9'h000, 1'b0, 16'h0000, 1'b1, 1'b1);
        add_row(OP_SAMPLE, 6'd9,  16'h0000, 9'h1ff, 9'h000, 1'b0, 16'h0000, 1'b0, 1'b1);
        add_row(OP_INTA,   6'd10, 16'h0000, 9'h000, 9'h000, 1'b0, 16'h0000, 1'b0, 1'b1);
        add_row(OP_MSKO,   6'd11, 16'h0000, 9'h000, 9'h000, 1'b0, 16'h0000, 1'b0, 1'b1);
        add_row(OP_SAMPLE, 6'd12, 16'h0000, 9'h180, 9'h000, 1'b0, 16'h0000, 1'b1, 1'b1);
        add_row(OP_INTA,   6'd13, 16'h0000, 9'h000, 9'h000, 1'b0, 16'h000e, 1'b1, 1'b1);
        add_row(OP_INTDS,  6'd14, 16'h0000, 9'h000, 9'h000, 1'b0, 16'h0000, 1'b0, 1'b0);
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

    initial begin
        int                              cycles;
        int                              slot;
        logic                            hit;
        logic [31:0]                     rnd;
        logic [N_DEV_DEF*KZ_W-1:0]       exp_kz;
        logic [DATA_W_DEF-1:0]           exp_rd;
        logic [STAT_W-1:0]               exp_stat;
        row_t                            r;

        op       = OP_DIA;                  // live read of slot 1 while reset is low
        addr     = 6'd8;
        bus_wr   = '0;
        dev_req  = '0;
        errors   = 0;
        n_checks = 0;
        n_rows   = 0;
        row_idx  = -1;
        seed     = 32'h75bd;
        for (int k = 0; k < N_DEV_DEF; k++) begin
            rnd         = $random(seed);
            dev_code[k] = 6'(7 + k);            // slot k answers to 7+k
            dev_data[k] = rnd[15:0];
            dev_stat[k] = 2'(k % 4);
        end
        build_table();

        @(negedge clk);                         // reset still asserted here
        check_value("o_dev_kz", 128'(dev_kz), 128'(0));   // reset state
        check_value("o_bus_rd", 128'(bus_rd), 128'(0));
        check_value("o_dev_stat", 128'(stat_rd), 128'(0));
        check_value("o_irq", 128'(irq), 128'(0));
        check_value("o_int_en", 128'(int_en), 128'(0));
        op   = OP_NOP;
        addr = '0;

        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                $display("Timeout: reset was not released after %0d cycles", cycles);
                $display("CHECKS FAILED");
                $finish;
            end
        end
        @(negedge clk);

        for (int i = 0; i < n_rows; i++) begin
            r       = rows[i];
            row_idx = i;
            op      = r.op;                     // driven on the falling edge
            addr    = r.addr;
            bus_wr  = r.bus;
            dev_req = r.req;
            @(negedge clk);                     // one rising edge later
            slot     = int'(r.addr) - 7;
            hit      = (slot >= 0) && (slot < N_DEV_DEF);
            exp_kz   = '0;
            exp_stat = '0;
            exp_rd   = r.rd;
            if (hit) begin
                exp_kz[slot*KZ_W +: KZ_W] = r.kz;
                exp_stat                  = 2'(slot % 4);
            end
            if (r.rd_dev) begin
                exp_rd = hit ? dev_data[slot] : '0;
            end
            check_value("o_dev_kz", 128'(dev_kz), 128'(exp_kz));
            check_value("o_bus_rd", 128'(bus_rd), 128'(exp_rd));
            check_value("o_dev_stat", 128'(stat_rd), 128'(exp_stat));
            check_value("o_irq", 128'(irq), 128'(r.irq));
            check_value("o_int_en", 128'(int_en), 128'(r.en));
        end

        $display("Summary: %0d checks, %0d errors", n_checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
design/io_pkg.sv
design/io_cmd_ctrl.sv
design/dev_select.sv
design/irq_mask_reg.sv
design/irq_prio_enc.sv
design/read_mux.sv
design/io_ctrl_top.sv
verification/io_ctrl_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the I/O controller testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module io_ctrl_tb -Mdir obj_dir -f all.f
status=$?
if [ $status -ne 0 ]; then
    echo "run.sh: verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vio_ctrl_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "run.sh: failure reported in $LOG"
    exit 1
fi

echo "run.sh: no failure found in $LOG"
exit 0
